//--- verilog/corr_geometry_pkg.sv
//////////////////////////////
// fixed 3-line, 3-lag array; baselines run (0,1), (0,2), (1,2)
//////////////////////////////

`default_nettype none

package corr_geometry_pkg;

	localparam int num_lines = 3;
	localparam int num_lags = 3; // slots hold lags -1, 0, +1 in that order
	localparam int num_baselines = 3;
	localparam int num_counts = num_baselines * num_lags;

	// agreement counters saturate rather than wrap
	localparam int count_width = 12;
	localparam int count_max = 4095;

	localparam int index_width = 4; // must cover num_counts - 1

endpackage

`default_nettype wire

//--- verilog/corr_control_pkg.sv
//////////////////////////////
// sequencer states and the integration length width
//////////////////////////////

`default_nettype none

package corr_control_pkg;

	// one pass is idle, integrate, readout and back to idle
	typedef enum logic [1:0] {
		st_idle,
		st_integrate,
		st_readout
	} seq_state_t;

	localparam int length_width = 16; // integration length in accepted samples

endpackage

`default_nettype wire

//--- verilog/corr_lag_array.sv
//////////////////////////////
// 1-bit samples, one tap of history per line
// counters saturate at count_max and clear only on clear or reset
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module corr_lag_array import corr_geometry_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire logic                   clear,
	input  wire logic                   sample_take,
	input  wire logic [num_lines-1:0]   samples,
	input  wire logic [index_width-1:0] read_index,
	output logic      [count_width-1:0] read_count
);

	logic [num_lines-1:0] tap; // previous accepted sample of each line
	logic [num_counts-1:0] agree;
	logic [count_width-1:0] counts [num_counts];

	// one agreement bit per baseline and lag slot
	for (genvar b = 0; b < num_baselines; b++) begin : g_baseline
		localparam int line_a = (b == 2) ? 1 : 0;
		localparam int line_b = (b == 0) ? 1 : 2;

		// lag -1 pairs the older sample of the first line with the new one of the second
		assign agree[b * num_lags + 0] = (tap[line_a] == samples[line_b]);
		assign agree[b * num_lags + 1] = (samples[line_a] == samples[line_b]);
		assign agree[b * num_lags + 2] = (samples[line_a] == tap[line_b]);
	end

	always_ff @(posedge clk) begin
		if (!reset || clear) begin
			tap <= '0; // taps read 0 before the first sample
		end else if (sample_take) begin
			tap <= samples;
		end
	end

	always_ff @(posedge clk) begin
		for (int k = 0; k < num_counts; k++) begin
			if (!reset || clear) begin
				counts[k] <= '0;
			end else if (sample_take && agree[k]) begin
				if (counts[k] != count_width'(count_max)) begin
					counts[k] <= counts[k] + 1'b1;
				end
			end
		end
	end

	// the readout walks the counters one at a time
	assign read_count = counts[read_index];

endmodule

`default_nettype wire

//--- verilog/corr_integration_timer.sv
//////////////////////////////
// length is latched on an idle start; later starts are ignored
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module corr_integration_timer import corr_control_pkg::*; (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    start,
	input  wire logic [length_width-1:0] int_length,
	input  wire logic                    sample_take,
	input  wire seq_state_t              state,
	output logic                         length_zero,
	output logic                         last_sample
);

	logic [length_width-1:0] length_reg;
	logic [length_width-1:0] sample_count; // samples accepted so far in this run

	always_ff @(posedge clk) begin
		if (start && state == st_idle) begin
			length_reg <= int_length;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			sample_count <= '0;
		end else if (start && state == st_idle) begin
			sample_count <= '0;
		end else if (sample_take) begin
			sample_count <= sample_count + 1'b1;
		end
	end

	assign length_zero = (int_length == '0); // live value, checked with the start itself
	assign last_sample = sample_take && (sample_count == length_reg - 1'b1);

endmodule

`default_nettype wire

//--- verilog/corr_sequencer.sv
//////////////////////////////
// start only counts in idle; clear is a one-cycle pulse with it
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module corr_sequencer import corr_control_pkg::*; (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic start,
	input  wire logic length_zero,
	input  wire logic last_sample,
	input  wire logic last_word_taken,
	output seq_state_t state,
	output logic      clear
);

	seq_state_t state_next;

	always_comb begin
		state_next = state;
		unique case (state)
			st_idle: begin
				if (start) begin
					// a zero length skips straight to reading out the cleared counts
					state_next = length_zero ? st_readout : st_integrate;
				end
			end
			st_integrate: begin
				if (last_sample) begin
					state_next = st_readout;
				end
			end
			st_readout: begin
				if (last_word_taken) begin
					state_next = st_idle;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	assign clear = start && (state == st_idle); // counters and taps zero on the start edge

endmodule

`default_nettype wire

//--- verilog/corr_readout.sv
//////////////////////////////
// nine words per run, index order baseline*3 + lag slot
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module corr_readout
	import corr_geometry_pkg::*;
	import corr_control_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   reset,
	input  wire seq_state_t             state,
	input  wire logic [count_width-1:0] read_count,
	input  wire logic                   out_ready,
	output logic      [index_width-1:0] read_index,
	output logic      [count_width-1:0] out_data,
	output logic                        out_valid,
	output logic                        out_last,
	output logic                        last_word_taken
);

	logic [index_width-1:0] index;

	always_ff @(posedge clk) begin
		if (!reset) begin
			index <= '0;
		end else if (state != st_readout) begin
			index <= '0; // every readout starts from the first counter
		end else if (out_valid && out_ready) begin
			index <= index + 1'b1;
		end
	end

	assign read_index = index;

	// counters are frozen during readout, so the word holds under back-pressure
	assign out_valid = (state == st_readout);
	assign out_data = read_count;
	assign out_last = out_valid && (index == index_width'(num_counts - 1));

	assign last_word_taken = out_last && out_ready;

endmodule

`default_nettype wire

//--- verilog/corr_top.sv
//////////////////////////////
// 1-bit lines only; a new run needs a start in idle
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module corr_top
	import corr_geometry_pkg::*;
	import corr_control_pkg::*;
(
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    start,
	input  wire logic [length_width-1:0] int_length,
	input  wire logic [num_lines-1:0]    samples,
	input  wire logic                    sample_valid,
	input  wire logic                    out_ready,
	output logic                         busy,
	output logic                         sample_ready,
	output logic      [count_width-1:0]  out_data,
	output logic                         out_last,
	output logic                         out_valid
);

	seq_state_t state;
	logic clear;
	logic length_zero;
	logic last_sample;
	logic last_word_taken;
	logic sample_take;
	logic [index_width-1:0] read_index;
	logic [count_width-1:0] read_count;

	assign sample_ready = (state == st_integrate);
	assign sample_take = sample_valid && sample_ready; // one accepted sample
	assign busy = (state != st_idle);

	corr_sequencer u_sequencer (
		.clk(clk), .reset(reset), .start(start),
		.length_zero(length_zero), .last_sample(last_sample),
		.last_word_taken(last_word_taken),
		.state(state), .clear(clear)
	);

	corr_integration_timer u_timer (
		.clk(clk), .reset(reset), .start(start), .int_length(int_length),
		.sample_take(sample_take), .state(state),
		.length_zero(length_zero), .last_sample(last_sample)
	);

	corr_lag_array u_lag_array (
		.clk(clk), .reset(reset), .clear(clear), .sample_take(sample_take),
		.samples(samples), .read_index(read_index), .read_count(read_count)
	);

	corr_readout u_readout (
		.clk(clk), .reset(reset), .state(state), .read_count(read_count),
		.out_ready(out_ready), .read_index(read_index), .out_data(out_data),
		.out_valid(out_valid), .out_last(out_last),
		.last_word_taken(last_word_taken)
	);

endmodule

`default_nettype wire

//--- bench/tb_corr_top.sv
//////////////////////////////
// seeded random stimulus; outputs are sampled on the falling edge
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_corr_top
	import corr_geometry_pkg::*;
	import corr_control_pkg::*;
();

	localparam int total_samples = 20 + 20 + 50 + 50 + 5000 + 0 + 12;
	localparam int num_runs = 7;
	localparam int cycle_limit = 2 * total_samples + 40 * num_runs + 10; // gaps can stretch a run

	logic clk = 1'b0;
	logic reset;
	logic start;
	logic [length_width-1:0] int_length;
	logic [num_lines-1:0] samples;
	logic sample_valid;
	logic out_ready;
	logic busy;
	logic sample_ready;
	logic [count_width-1:0] out_data;
	logic out_last;
	logic out_valid;

	int seed = 32'h006b_3b5f;
	int cycles = 0;
	int errors = 0;
	int errors_before = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	// line pairs of the three baselines, in readout order
	int first_line [num_baselines] = '{0, 0, 1};
	int second_line [num_baselines] = '{1, 2, 2};

	logic [num_lines-1:0] history; // previous accepted sample of each line
	logic [count_width-1:0] expected [num_counts];
	logic [count_width-1:0] words [num_counts]; // words taken in the latest readout

	corr_top DUT (
		.clk(clk), .reset(reset), .start(start), .int_length(int_length),
		.samples(samples), .sample_valid(sample_valid), .out_ready(out_ready),
		.busy(busy), .sample_ready(sample_ready), .out_data(out_data),
		.out_last(out_last), .out_valid(out_valid)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("Timeout: the tests did not finish within %0d cycles", cycle_limit);
			$display("Something failed");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input int want, input int got);
		$display("Mismatch at %0t ns: %s expected %0d, got %0d", $time, name, want, got);
		errors++;
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic model_clear();
		history = '0;
		for (int k = 0; k < num_counts; k++) begin
			expected[k] = '0;
		end
	endtask

	// applies the agreement rule for lags -1, 0 and +1 to one accepted sample
	task automatic model_take(input logic [num_lines-1:0] s);
		logic agree [num_lags];
		int slot;
		for (int p = 0; p < num_baselines; p++) begin
			agree[0] = (history[first_line[p]] == s[second_line[p]]);
			agree[1] = (s[first_line[p]] == s[second_line[p]]);
			agree[2] = (s[first_line[p]] == history[second_line[p]]);
			for (int l = 0; l < num_lags; l++) begin
				slot = p * num_lags + l;
				if (agree[l] && expected[slot] != count_width'(count_max)) begin
					expected[slot] = expected[slot] + 1'b1;
				end
			end
		end
		history = s;
	endtask

	// lag-0 words of the latest readout, one expected count per baseline
	task automatic check_lag0(input int want0, input int want1, input int want2);
		int want [num_baselines];
		want = '{want0, want1, want2};
		for (int p = 0; p < num_baselines; p++) begin
			assert (int'(words[p * num_lags + 1]) == want[p])
				else report_mismatch("out_data", want[p], int'(words[p * num_lags + 1]));
		end
	endtask

	function automatic logic [num_lines-1:0] next_samples(input int pattern);
		logic r;
		r = (($random(seed) & 1) != 0);
		case (pattern)
			1: next_samples = {num_lines{r}};
			2: next_samples = {~r, r, r}; // line 2 carries the complement
			default: next_samples = num_lines'($random(seed));
		endcase
	endfunction

	task automatic start_run(input int len);
		@(posedge clk);
		start <= 1'b1;
		int_length <= length_width'(len);
		@(posedge clk);
		start <= 1'b0;
		model_clear();
	endtask

	// poke raises start halfway through with a shorter length, which must be ignored
	task automatic integrate(input int len, input int pattern, input bit gaps, input bit poke);
		int accepted;
		accepted = 0;
		int_length <= poke ? length_width'(3) : int_length;
		while (accepted < len) begin
			samples <= next_samples(pattern);
			sample_valid <= gaps ? (($random(seed) & 3) != 0) : 1'b1;
			start <= poke && (accepted == len / 2);
			@(negedge clk);
			assert (sample_ready)
				else report_failure("sample_ready low before the run length was reached");
			if (sample_valid && sample_ready) begin
				model_take(samples);
				accepted++;
			end
			@(posedge clk);
		end
		sample_valid <= 1'b0;
		start <= 1'b0;
	endtask

	task automatic readout(input bit backpressure);
		int idx;
		logic held;
		logic [count_width-1:0] held_data;
		logic held_last;
		idx = 0;
		held = 1'b0;
		held_data = '0;
		held_last = 1'b0;
		while (idx < num_counts) begin
			out_ready <= backpressure ? (($random(seed) & 1) != 0) : 1'b1;
			@(negedge clk);
			assert (out_valid && busy && !sample_ready)
				else report_failure("out_valid low or sample_ready high during readout");
			assert (out_data == expected[idx])
				else report_mismatch("out_data", int'(expected[idx]), int'(out_data));
			assert (out_last == (idx == num_counts - 1))
				else report_mismatch("out_last", (idx == num_counts - 1) ? 1 : 0, int'(out_last));
			if (held) begin
				assert (out_data == held_data && out_last == held_last)
					else report_failure("output word changed while out_ready was low");
			end
			held = !out_ready;
			held_data = out_data;
			held_last = out_last;
			if (out_ready) begin
				words[idx] = out_data;
				idx++;
			end
			@(posedge clk);
		end
		out_ready <= 1'b0;
		@(negedge clk);
		assert (!busy && !out_valid) else report_failure("busy or out_valid high after the last word");
	endtask

	task automatic finish_test(input string name);
		if (errors == errors_before) begin
			tests_passed++;
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail with %0d errors", name, errors - errors_before);
		end
		errors_before = errors;
	endtask

	initial begin
		reset <= 1'b0;
		start <= 1'b0;
		int_length <= '0;
		samples <= '0;
		sample_valid <= 1'b0;
		out_ready <= 1'b0;
		model_clear();
		repeat (3) @(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		assert (!busy && !sample_ready && !out_valid)
			else report_failure("busy, sample_ready or out_valid high after reset");
		finish_test("reset state");

		start_run(20);
		integrate(20, 0, 1'b1, 1'b0);
		readout(1'b0);
		finish_test("random run with sample gaps");

		start_run(20);
		integrate(20, 0, 1'b0, 1'b0);
		readout(1'b1);
		finish_test("output back-pressure");

		start_run(50);
		integrate(50, 1, 1'b0, 1'b0);
		readout(1'b0);
		check_lag0(50, 50, 50);
		start_run(50);
		integrate(50, 2, 1'b0, 1'b0);
		readout(1'b0);
		check_lag0(50, 0, 0);
		finish_test("identical and complemented lines");

		start_run(5000);
		integrate(5000, 1, 1'b0, 1'b0);
		readout(1'b0);
		check_lag0(count_max, count_max, count_max);
		finish_test("counter saturation");

		start_run(0);
		readout(1'b0);
		start_run(12);
		integrate(12, 0, 1'b0, 1'b1);
		readout(1'b0);
		finish_test("zero length and ignored start");

		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
verilog/corr_geometry_pkg.sv
verilog/corr_control_pkg.sv
verilog/corr_lag_array.sv
verilog/corr_integration_timer.sv
verilog/corr_sequencer.sv
verilog/corr_readout.sv
verilog/corr_top.sv
bench/tb_corr_top.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and decide the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_corr_top -f sim.f -o tb_corr_top > build.log 2>&1 \
	&& ./obj_dir/tb_corr_top > sim.log 2>&1 \
	|| { echo "build or run failed"; cat build.log; exit 1; }
cat sim.log
grep -q "Everything OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
